//--- Makefile
# Verilator simulation of the cache testbench

VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cache_tb
FILELIST = sources.f
OBJ_DIR = obj_dir

.PHONY: sim clean

# a failing run ends in $fatal, which gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/cache.sv
`timescale 1ns/100ps
`include "cache_config.svh"

module cache (
	input logic clk,
	input logic reset,

	// pipeline side
	input logic mem_read, // pipeline wants a word
	input logic mem_write, // pipeline wants to store a word
	input logic [`CACHE_ADDR_W-1:0] read_addr, // pc or load address
	input logic [`CACHE_ADDR_W-1:0] write_addr, // store address
	input logic [`CACHE_DATA_W-1:0] write_data, // store data
	output logic [`CACHE_DATA_W-1:0] data_out, // word read from the cache
	output logic hit,
	output logic stall, // hold the pipeline while a fill runs

	// memory side
	input logic mem_data_valid, // returned word is on mem_read_data
	input logic [`CACHE_DATA_W-1:0] mem_read_data,
	output logic mem_read_req, // held high for the whole fill
	output logic mem_write_req, // one cycle per write hit
	output logic [`CACHE_ADDR_W-1:0] mem_addr,
	output logic [`CACHE_DATA_W-1:0] mem_write_data
);

	import cache_pkg::*;

	cache_addr_u req_addr; // request address, lookup view
	cache_addr_u fill_addr; // word being fetched by the fill
	cache_meta_t meta_rd; // metadata of the addressed set
	cache_meta_t meta_wr; // metadata stored at the end of a fill
	logic request; // read or write present
	logic miss;
	logic busy;
	logic fill_word_write;
	logic tag_write;
	logic write_hit; // store that lands in the cache and memory
	logic data_write;
	logic [2:0] word_sel;
	logic [`CACHE_DATA_W-1:0] data_in;

	assign req_addr = mem_write ? write_addr : read_addr; // write address wins
	assign request = mem_read | mem_write;

	assign hit = meta_rd.valid & (meta_rd.tag == req_addr.lookup.tag);
	assign miss = request & ~hit & ~busy;
	assign stall = busy | miss; // up already in the miss cycle

	assign write_hit = mem_write & hit & ~busy;
	assign data_write = fill_word_write | write_hit;

	// array inputs come from memory during a fill
	assign word_sel = busy ? fill_addr.lookup.offset[3:1] : req_addr.lookup.offset[3:1];
	assign data_in = busy ? mem_read_data : write_data;

	assign meta_wr.valid = 1'b1;
	assign meta_wr.tag = req_addr.lookup.tag; // request is held through the fill

	// memory port
	assign mem_read_req = busy;
	assign mem_write_req = write_hit; // write-through, same cycle as the array
	assign mem_addr = busy ? fill_addr : req_addr;
	assign mem_write_data = write_data;

	cache_fill_fsm fill_ctrl (
		.clk(clk),
		.reset(reset),
		.miss(miss),
		.mem_data_valid(mem_data_valid),
		.miss_addr(req_addr),
		.busy(busy),
		.fill_addr(fill_addr),
		.fill_word_write(fill_word_write),
		.tag_write(tag_write)
	);

	cache_tag_array tag_array (
		.clk(clk),
		.reset(reset),
		.index(req_addr.lookup.index),
		.write(tag_write),
		.meta_in(meta_wr),
		.meta_out(meta_rd)
	);

	cache_data_array data_array (
		.clk(clk),
		.reset(reset),
		.index(req_addr.lookup.index),
		.word(word_sel),
		.write(data_write),
		.data_in(data_in),
		.data_out(data_out)
	);

endmodule

//--- logic/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// address and data word widths
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 16

// address split into tag, set index and block offset
`define CACHE_TAG_W 5 // upper address bits
`define CACHE_INDEX_W 7 // selects one of the sets
`define CACHE_OFFSET_W 4 // word within block plus an unused low bit

// array geometry
`define CACHE_SETS 128 // 2**CACHE_INDEX_W
`define CACHE_WORDS 8 // words per block, picked by offset[3:1]

// miss block number as seen by the fill controller
`define CACHE_BLOCK_W (`CACHE_TAG_W + `CACHE_INDEX_W)

`endif

//--- logic/cache_data_array.sv
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_data_array (
	input logic clk,
	input logic reset,
	input logic [`CACHE_INDEX_W-1:0] index, // set select
	input logic [2:0] word, // word within the block
	input logic write, // store data_in at set and word
	input logic [`CACHE_DATA_W-1:0] data_in,
	output logic [`CACHE_DATA_W-1:0] data_out // selected word
);

	import cache_pkg::*;

	logic [`CACHE_SETS-1:0] set_sel; // one-hot set select
	logic [`CACHE_WORDS-1:0] word_sel; // one-hot word select
	logic [`CACHE_DATA_W-1:0] block_out [`CACHE_WORDS]; // words of the selected set
	logic [`CACHE_DATA_W-1:0] store [`CACHE_SETS][`CACHE_WORDS]; // no reset on contents

	always_comb begin
		set_sel = '0;
		set_sel[index] = 1'b1;
	end

	always_comb begin
		word_sel = '0;
		word_sel[word] = 1'b1;
	end

	// pick the block with the set select first
	always_comb begin
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			block_out[w] = '0;
			for (int s = 0; s < `CACHE_SETS; s++) begin
				block_out[w] = block_out[w] | (store[s][w] & {`CACHE_DATA_W{set_sel[s]}});
			end
		end
	end

	// then the word with the word select
	always_comb begin
		data_out = '0;
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			data_out = data_out | (block_out[w] & {`CACHE_DATA_W{word_sel[w]}});
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < `CACHE_SETS; s++) begin
			for (int w = 0; w < `CACHE_WORDS; w++) begin
				if (write && set_sel[s] && word_sel[w]) begin
					store[s][w] <= data_in; // single word per edge
				end
			end
		end
	end

	// memory data or pipeline data must be real when it is stored
	a_data_known: assert property (@(posedge clk) disable iff (reset)
		write |-> !$isunknown(data_in));

endmodule

//--- logic/cache_fill_fsm.sv
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_fill_fsm (
	input logic clk,
	input logic reset,
	input logic miss, // request with no hit while idle
	input logic mem_data_valid, // one pulse per returned word
	input cache_pkg::cache_addr_u miss_addr, // address that missed
	output logic busy, // fill in progress
	output cache_pkg::cache_addr_u fill_addr, // word currently requested from memory
	output logic fill_word_write, // write returned word into data array
	output logic tag_write // write tag on the last word
);

	import cache_pkg::*;

	localparam logic S_IDLE = 1'b0;
	localparam logic S_FILL = 1'b1;
	localparam logic [2:0] LAST_WORD = 3'(`CACHE_WORDS - 1);

	logic state; // current controller state
	logic state_next;
	logic start; // miss accepted this cycle
	logic last_word; // final word of the block arrives
	logic [2:0] word_cnt; // word index within the block
	logic [`CACHE_BLOCK_W-1:0] block_reg; // latched miss block

	assign busy = (state == S_FILL);
	assign start = (state == S_IDLE) & miss;
	assign fill_word_write = busy & mem_data_valid;
	assign last_word = fill_word_write & (word_cnt == LAST_WORD);
	assign tag_write = last_word; // tag goes in with the final word

	// memory address of the word being fetched
	always_comb begin
		fill_addr.fill.block = block_reg;
		fill_addr.fill.word_offset = {word_cnt, 1'b0}; // low bit of offset is unused
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (start) begin
					state_next = S_FILL; // fill starts on the next edge
				end
			end
			S_FILL: begin
				if (last_word) begin
					state_next = S_IDLE; // held request hits next cycle
				end
			end
			default: begin
				state_next = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			word_cnt <= '0;
		end else begin
			state <= state_next;
			if (start) begin
				word_cnt <= '0; // every fill begins at word 0
			end else if (fill_word_write) begin
				word_cnt <= word_cnt + 3'd1; // advance only when memory answers
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			block_reg <= miss_addr.fill.block; // block number of the miss
		end
	end

	// a fill only ever starts from a detected miss
	a_busy_from_miss: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> $past(miss));

	// memory sees a steady address while it is still working on a word
	a_fill_addr_stable: assert property (@(posedge clk) disable iff (reset)
		busy && !mem_data_valid |=> $stable(fill_addr));

endmodule

//--- logic/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

	// one address word with two decodings
	typedef union packed {
		struct packed {
			logic [`CACHE_TAG_W-1:0] tag; // compared against stored tag
			logic [`CACHE_INDEX_W-1:0] index; // set select
			logic [`CACHE_OFFSET_W-1:0] offset; // bits 3..1 pick the word, bit 0 unused
		} lookup; // view used by the arrays and hit logic
		struct packed {
			logic [`CACHE_BLOCK_W-1:0] block; // tag and index together
			logic [`CACHE_OFFSET_W-1:0] word_offset; // stepped by the fill
		} fill; // view used to walk the block during a fill
	} cache_addr_u;

	// per-set metadata
	typedef struct packed {
		logic valid; // block holds data from memory
		logic [`CACHE_TAG_W-1:0] tag; // tag of the resident block
	} cache_meta_t;

endpackage

//--- logic/cache_tag_array.sv
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_tag_array (
	input logic clk,
	input logic reset,
	input logic [`CACHE_INDEX_W-1:0] index, // set being looked up or filled
	input logic write, // store meta_in into the selected set
	input cache_pkg::cache_meta_t meta_in,
	output cache_pkg::cache_meta_t meta_out // metadata of the selected set
);

	import cache_pkg::*;

	logic [`CACHE_SETS-1:0] set_sel; // one-hot set select
	logic [`CACHE_SETS-1:0] valid; // one valid bit per set
	logic [`CACHE_TAG_W-1:0] tags [`CACHE_SETS]; // tag per set

	always_comb begin
		set_sel = '0;
		set_sel[index] = 1'b1; // index decode
	end

	// combinational read as an and-or over the one-hot select
	always_comb begin
		meta_out.valid = |(valid & set_sel);
		meta_out.tag = '0;
		for (int s = 0; s < `CACHE_SETS; s++) begin
			meta_out.tag = meta_out.tag | (tags[s] & {`CACHE_TAG_W{set_sel[s]}});
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0; // cache comes up empty
		end else if (write) begin
			valid <= valid | set_sel; // only the selected set changes
			if (!meta_in.valid) begin
				valid <= valid & ~set_sel;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < `CACHE_SETS; s++) begin
			if (write && set_sel[s]) begin
				tags[s] <= meta_in.tag; // guarded by the valid bit
			end
		end
	end

	// the fill controller must stay quiet while the cache is held in reset
	a_no_write_in_reset: assert property (@(posedge clk)
		reset |-> !write);

endmodule

//--- sources.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_fill_fsm.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache.sv
verification/cache_tb_memory.sv
verification/cache_tb.sv

//--- verification/cache_tb.sv
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_tb;

	localparam logic [31:0] SEED = 32'heea61e2d;
	localparam int NUM_OPS = 400;
	localparam int RESET_CYCLES = 16;
	localparam int BLOCK_WORDS = 8;
	localparam int CYCLE_LIMIT = NUM_OPS * (8 * 7 + 4) + RESET_CYCLES; // worst fill plus slack
	localparam int CHK_IDLE = 0; // waiting for a request
	localparam int CHK_FILL = 1; // miss seen, following the fill
	localparam int CHK_REFILLED = 2; // tag written, request must hit now

	logic clk;
	logic reset;
	logic mem_read;
	logic mem_write;
	logic [`CACHE_ADDR_W-1:0] read_addr;
	logic [`CACHE_ADDR_W-1:0] write_addr;
	logic [`CACHE_DATA_W-1:0] write_data;
	logic [`CACHE_DATA_W-1:0] data_out;
	logic hit;
	logic stall;
	logic mem_data_valid;
	logic [`CACHE_DATA_W-1:0] mem_read_data;
	logic mem_read_req;
	logic mem_write_req;
	logic [`CACHE_ADDR_W-1:0] mem_addr;
	logic [`CACHE_DATA_W-1:0] mem_write_data;
	logic [2:0] mem_latency; // next memory delay, fresh every cycle

	logic [31:0] rand_state; // stimulus stream
	logic [31:0] lat_state; // latency stream, separate so processes do not share it
	logic op_write; // current request, set by the stimulus
	logic [15:0] op_addr;
	logic [15:0] op_data;
	int ops_issued;
	int ops_done;
	int chk_state;
	int fill_words; // valid pulses seen in the current fill

	// reference model state
	logic ref_valid [128];
	logic [4:0] ref_tag [128];
	logic [15:0] ref_mem [65536]; // memory and every valid cache block agree

	cache uut (
		.clk(clk),
		.reset(reset),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.read_addr(read_addr),
		.write_addr(write_addr),
		.write_data(write_data),
		.data_out(data_out),
		.hit(hit),
		.stall(stall),
		.mem_data_valid(mem_data_valid),
		.mem_read_data(mem_read_data),
		.mem_read_req(mem_read_req),
		.mem_write_req(mem_write_req),
		.mem_addr(mem_addr),
		.mem_write_data(mem_write_data)
	);

	cache_tb_memory main_mem (
		.clk(clk),
		.reset(reset),
		.latency(mem_latency),
		.mem_read_req(mem_read_req),
		.mem_write_req(mem_write_req),
		.mem_addr(mem_addr),
		.mem_write_data(mem_write_data),
		.mem_data_valid(mem_data_valid),
		.mem_read_data(mem_read_data)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// same power-up content as the memory model
	function automatic logic [15:0] memory_pattern(input logic [15:0] addr);
		return (addr * 16'h9e37) ^ {addr[7:0], addr[15:8]} ^ 16'h5ac3;
	endfunction

	// tag 15:11, index 10:4, word 3:1, bit 0 ignored
	function automatic logic reference_lookup(input logic [15:0] addr, output logic [15:0] data);
		logic [6:0] idx;
		idx = addr[10:4];
		data = ref_mem[{addr[15:1], 1'b0}];
		return ref_valid[idx] && (ref_tag[idx] == addr[15:11]);
	endfunction

	// few tags over a handful of sets, half the time the last block again
	function automatic logic [15:0] pick_address(input logic [15:0] r, input logic [15:0] last,
			input logic is_write);
		logic [4:0] tag;
		logic [6:0] idx;
		case (r[1:0])
			2'd0: tag = 5'h03;
			2'd1: tag = 5'h0e;
			2'd2: tag = 5'h15;
			default: tag = 5'h1f;
		endcase
		case (r[4:2])
			3'd0: idx = 7'd0;
			3'd1: idx = 7'd1;
			3'd2: idx = 7'd37;
			3'd3: idx = 7'd64;
			3'd4: idx = 7'd100;
			default: idx = 7'd127;
		endcase
		if (r[11:9] < 3'd4) begin
			tag = last[15:11];
			idx = last[10:4];
		end
		return {tag, idx, r[7:5], is_write ? 1'b0 : r[8]}; // stores stay on even words
	endfunction

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic draw_random(output logic [15:0] r);
		rand_state = lcg_next(rand_state);
		r = rand_state[31:16]; // upper bits have the longer period
	endtask

	task automatic issue_op(input logic is_write, input logic [15:0] addr,
			input logic [15:0] data, input logic [15:0] decoy);
		op_write = is_write;
		op_addr = addr;
		op_data = data;
		mem_read <= !is_write;
		mem_write <= is_write;
		read_addr <= is_write ? decoy : addr; // unused address gets noise
		write_addr <= is_write ? addr : decoy;
		write_data <= data;
		ops_issued++;
	endtask

	task automatic install_block(input logic [15:0] addr);
		ref_valid[addr[10:4]] = 1'b1;
		ref_tag[addr[10:4]] = addr[15:11];
	endtask

	// request is served in this cycle
	task automatic complete_op(input logic [15:0] exp_data);
		check_value("stall", 16'(stall), 16'd0);
		check_value("mem_read_req", 16'(mem_read_req), 16'd0);
		if (op_write) begin
			check_value("mem_write_req", 16'(mem_write_req), 16'd1);
			check_value("mem_addr", mem_addr, op_addr);
			check_value("mem_write_data", mem_write_data, op_data);
			ref_mem[op_addr] = op_data; // cache and memory take it on the same edge
		end else begin
			check_value("mem_write_req", 16'(mem_write_req), 16'd0);
			check_value("data_out", data_out, exp_data);
		end
		ops_done++;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		mem_latency = 3'd1;
		lat_state = ~SEED;
		forever begin
			@(posedge clk);
			lat_state = lcg_next(lat_state);
			mem_latency <= 3'd1 + 3'(lat_state[31:16] % 16'd6); // 1 to 6 cycles
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("TEST FAILED");
		$fatal(1, "timeout after %0d cycles, the operation sequence did not finish", cycles);
	end

	// compares at the falling edge, where every output has settled
	initial begin : compare
		logic exp_hit;
		logic [15:0] exp_data;
		chk_state = CHK_IDLE;
		ops_done = 0;
		fill_words = 0;
		for (int s = 0; s < 128; s++) begin
			ref_valid[s] = 1'b0; // cache comes up empty
			ref_tag[s] = 5'd0;
		end
		for (int a = 0; a < 65536; a++) begin
			ref_mem[a] = memory_pattern(16'(a));
		end
		forever begin
			@(negedge clk);
			if (!reset) begin
				case (chk_state)
					CHK_IDLE: begin
						if (ops_issued == ops_done) begin
							check_value("stall", 16'(stall), 16'd0); // quiet with no request
							check_value("mem_read_req", 16'(mem_read_req), 16'd0);
							check_value("mem_write_req", 16'(mem_write_req), 16'd0);
						end else begin
							exp_hit = reference_lookup(op_addr, exp_data);
							check_value("hit", 16'(hit), 16'(exp_hit));
							if (exp_hit) begin
								complete_op(exp_data); // zero-cycle hit
							end else begin
								check_value("stall", 16'(stall), 16'd1); // up in the miss cycle
								check_value("mem_read_req", 16'(mem_read_req), 16'd0);
								check_value("mem_write_req", 16'(mem_write_req), 16'd0);
								fill_words = 0;
								chk_state = CHK_FILL;
							end
						end
					end
					CHK_FILL: begin
						check_value("stall", 16'(stall), 16'd1);
						check_value("hit", 16'(hit), 16'd0);
						check_value("mem_read_req", 16'(mem_read_req), 16'd1);
						check_value("mem_write_req", 16'(mem_write_req), 16'd0);
						check_value("mem_addr", mem_addr, {op_addr[15:4], 3'(fill_words), 1'b0});
						if (mem_data_valid) begin
							fill_words++;
							if (fill_words == BLOCK_WORDS) begin
								install_block(op_addr); // tag lands with the last word
								chk_state = CHK_REFILLED;
							end
						end
					end
					default: begin
						exp_hit = reference_lookup(op_addr, exp_data);
						check_value("hit", 16'(hit), 16'(exp_hit));
						complete_op(exp_data);
						chk_state = CHK_IDLE;
					end
				endcase
			end
		end
	end

	initial begin : stimulus
		logic [15:0] r;
		logic is_write;
		logic [15:0] addr;
		logic [15:0] data;
		logic [15:0] decoy;
		logic [15:0] last_addr;
		reset = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		read_addr = '0;
		write_addr = '0;
		write_data = '0;
		rand_state = SEED;
		ops_issued = 0;
		last_addr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk); // one idle cycle right after reset
		for (int n = 0; n < NUM_OPS; n++) begin
			draw_random(r);
			is_write = (r[15:13] < 3'd3); // about three stores in eight
			draw_random(r);
			addr = pick_address(r, last_addr, is_write);
			draw_random(data);
			draw_random(decoy);
			issue_op(is_write, addr, data, decoy);
			last_addr = addr;
			do @(posedge clk); while (ops_done != ops_issued);
			draw_random(r);
			if (r[15:14] == 2'd0) begin
				mem_read <= 1'b0; // occasional gap between requests
				mem_write <= 1'b0;
				@(posedge clk);
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- verification/cache_tb_memory.sv
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_tb_memory (
	input logic clk,
	input logic reset,
	input logic [2:0] latency, // cycles until the next word, 1 to 6
	input logic mem_read_req, // held high for a whole fill
	input logic mem_write_req, // write-through from the cache
	input logic [`CACHE_ADDR_W-1:0] mem_addr,
	input logic [`CACHE_DATA_W-1:0] mem_write_data,
	output logic mem_data_valid, // one pulse per word
	output logic [`CACHE_DATA_W-1:0] mem_read_data
);

	localparam int DEPTH = 1 << `CACHE_ADDR_W;

	logic [`CACHE_DATA_W-1:0] store [DEPTH]; // main memory contents
	logic [2:0] wait_left; // edges left before the next valid

	// power-up content, every address bit takes part
	function automatic logic [15:0] shadow_content(input logic [15:0] addr);
		return (addr * 16'h9e37) ^ {addr[7:0], addr[15:8]} ^ 16'h5ac3;
	endfunction

	initial begin
		mem_data_valid = 1'b0;
		mem_read_data = '0;
		wait_left = 3'd0;
		for (int a = 0; a < DEPTH; a++) begin
			store[a] = shadow_content(16'(a));
		end
		forever begin
			@(posedge clk);
			if (reset) begin
				mem_data_valid <= 1'b0;
				wait_left <= latency - 3'd1;
			end else begin
				if (mem_write_req) begin
					store[mem_addr] <= mem_write_data; // writes are always accepted
				end
				if (mem_data_valid) begin
					mem_data_valid <= 1'b0; // pulse lasts one cycle
					wait_left <= latency - 3'd1; // fresh delay for the next word
				end else if (mem_read_req) begin
					if (wait_left == 3'd0) begin
						mem_data_valid <= 1'b1;
						mem_read_data <= store[mem_addr]; // address is steady until valid
					end else begin
						wait_left <= wait_left - 3'd1;
					end
				end
			end
		end
	end

endmodule
